//--- tpl_dac.f
hw/tpl_dac_pkg.sv
hw/tpl_dac_regmap.sv
hw/tpl_dac_channel.sv
hw/tpl_dac_framer.sv
hw/tpl_dac_core.sv
hw/tpl_dac.sv
sim/tpl_dac_tb.sv

//--- sim/tpl_dac_stim.txt
# one command per line, hex arguments
# W adr data [sel] | R adr expected | N enable mask | G run link
# D ch0 word ch1 word, sample 1 in the high half | E beat {lane1, lane0}
N 0
R 00 7da10100
R 04 00000000
R 08 00000000
R 0c 10020202
R 40 00000003
R 50 00000003
# byte select writes
W 44 a1b2c3d4
R 44 a1b2c3d4
W 44 00ff0000 4
R 44 a1ffc3d4
W 54 11223344 9
R 54 11000044
# pattern source on both channels
W 44 abcd1234
W 54 7ffe8001
W 40 00000001
W 50 00000001
W 04 00000001
R 04 00000001
E fe7f0180cdab3412
E fe7f0180cdab3412
E fe7f0180cdab3412
G
W 04 00000000
R 04 00000000
# ramp source with 16 bit wraparound
W 48 0007fff0
W 58 ff800100
W 40 00000002
W 50 00000002
W 04 00000001
E 80000001f7fff0ff
E 80ff00000500feff
E 80fe00ff13000c00
E 80fd00fe21001a00
G
W 04 00000000
# dma source, the last two words only fill the pipeline
W 40 00000000
W 50 00000000
W 04 00000001
N 3
D 03040102 83848182
D 13141112 93949192
D a3a4a1a2 53545152
D f00dc0de 0bad7e57
D 5a5a5a5a a5a5a5a5
D 5a5a5a5a a5a5a5a5
E 8483828104030201
E 9493929114131211
E 54535251a4a3a2a1
E ad0b577e0df0dec0
G
W 04 00000000
R 08 00000000
# zero source on ch0, pattern on ch1
W 40 00000003
W 50 00000001
W 04 00000001
N 0
E fe7f018000000000
E fe7f018000000000
G
W 04 00000000
# ch0 on dma with nothing queued
W 40 00000000
W 04 00000001
N 1
E fe7f018000000000
E fe7f018000000000
G
W 04 00000000
R 08 00000001
W 08 00000001
R 08 00000000

//--- sim/tpl_dac_tb.sv
// ********************
// tpl_dac_tb
// runs the transport layer from the stim file: Wishbone
// accesses, dma words and expected link beats
// ********************

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_tb
  import tpl_dac_pkg::*;
();

  localparam logic [31:0] dut_id      = 32'h7da1_0100;
  localparam int          cycle_limit = 200;

  logic                          link_clk;
  logic                          rst;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [7:0]                    wb_adr;
  logic [31:0]                   wb_dat_w;
  logic [3:0]                    wb_sel;
  logic [31:0]                   wb_dat_r;
  logic                          wb_ack;
  logic                          link_valid;
  logic                          link_ready;
  link_beat_u                    link_data;
  logic [num_channels-1:0]       enable;
  logic [num_channels-1:0]       dac_valid;
  chan_beat_t [num_channels-1:0] dac_ddata;
  logic                          dac_dunf;

  // dma words {ch1, ch0} and expected beats, oldest first
  logic [63:0] dma_q[$];
  link_beat_u  exp_q[$];

  logic [31:0] rng;
  logic        link_active;
  logic        prev_valid;
  int          discard;

  tpl_dac #(
    .ID (dut_id)
  ) i_tpl_dac (
    .link_clk   (link_clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_data  (link_data),
    .enable     (enable),
    .dac_valid  (dac_valid),
    .dac_ddata  (dac_ddata),
    .dac_dunf   (dac_dunf)
  );

  initial begin
    link_clk = 1'b0;
    forever begin
      #5 link_clk = ~link_clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // ********************
  // compare tasks
  // ********************

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED t=%0d ns %s expected %08h got %08h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_beat(input string name, input link_beat_u exp,
                            input link_beat_u act);
    if (act.lanes !== exp.lanes) begin
      abort_run($sformatf("CHECK FAILED t=%0d ns %s expected %016h got %016h",
                          $time, name, exp.lanes, act.lanes));
    end
  endtask

  task automatic check_enable(input string name, input logic [num_channels-1:0] exp,
                              input logic [num_channels-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED t=%0d ns %s expected %b got %b",
                          $time, name, exp, act));
    end
  endtask

  // first two beats after each run edge carry the cleared pipeline
  task automatic take_beat();
    link_beat_u exp;
    if (discard > 0) begin
      discard--;
    end else if (exp_q.size() == 0) begin
      abort_run($sformatf("link beat at %0d ns with no expected value left", $time));
    end else begin
      exp = exp_q.pop_front();
      check_beat("link_data", exp, link_data);
    end
  endtask

  // one clock: sample at the edge, drive 1 ns later
  task automatic step_clock();
    @(posedge link_clk);
    if (link_valid && !prev_valid) begin
      discard = 2;
    end
    prev_valid = link_valid;
    if ((|dac_valid) && dma_q.size() > 0) begin
      void'(dma_q.pop_front());
    end
    if (link_valid && link_ready) begin
      take_beat();
    end
    #1;
    if (link_active) begin
      rng        = xorshift32(rng);
      link_ready = (rng[1:0] != 2'b00);
    end else begin
      link_ready = 1'b0;
    end
    dac_dunf  = (dma_q.size() == 0);
    dac_ddata = (dma_q.size() > 0) ? dma_q[0] : '0;
  endtask

  task automatic wb_access(input logic we, input logic [7:0] adr,
                           input logic [31:0] dat, input logic [3:0] sel,
                           output logic [31:0] rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    waited   = 0;
    step_clock();
    while (wb_ack !== 1'b1) begin
      if (waited == cycle_limit) begin
        abort_run($sformatf("no Wishbone ack for address %02h after %0d cycles",
                            adr, cycle_limit));
      end
      step_clock();
      waited++;
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic run_link();
    int waited;
    int left;
    waited      = 0;
    link_active = 1'b1;
    while (exp_q.size() > 0) begin
      if (waited == cycle_limit) begin
        abort_run($sformatf("link beat missing after %0d cycles", cycle_limit));
      end
      left = exp_q.size();
      step_clock();
      waited = (exp_q.size() != left) ? 0 : waited + 1;
    end
    link_active = 1'b0;
    link_ready  = 1'b0;
  endtask

  // ********************
  // stim file
  // ********************

  initial begin
    int          fd;
    int          n;
    string       line;
    byte         cmd;
    logic [63:0] a0;
    logic [63:0] a1;
    logic [63:0] a2;
    logic [31:0] rdata;
    link_beat_u  beat;

    rst         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    wb_sel      = '0;
    link_ready  = 1'b0;
    dac_ddata   = '0;
    dac_dunf    = 1'b0;
    rng         = 32'hba1cef83;
    link_active = 1'b0;
    prev_valid  = 1'b0;
    discard     = 0;
    repeat (4) @(posedge link_clk);
    #1;
    rst = 1'b0;

    fd = $fopen("sim/tpl_dac_stim.txt", "r");
    if (fd == 0) begin
      abort_run("could not open sim/tpl_dac_stim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      a2 = 64'hf;
      n  = $sscanf(line, "%c %h %h %h", cmd, a0, a1, a2);
      case (cmd)
        "W": wb_access(1'b1, a0[7:0], a1[31:0], (n > 3) ? a2[3:0] : 4'hf, rdata);
        "R": begin
          wb_access(1'b0, a0[7:0], 32'h0, 4'hf, rdata);
          check_word($sformatf("wb_dat_r @%02h", a0[7:0]), a1[31:0], rdata);
        end
        "N": check_enable("enable", a0[num_channels-1:0], enable);
        "D": dma_q.push_back({a1[31:0], a0[31:0]});
        "E": begin
          beat = a0;
          exp_q.push_back(beat);
        end
        "G": run_link();
        default: abort_run($sformatf("unknown command in stim file: %s", line));
      endcase
    end
    $fclose(fd);

    if (exp_q.size() != 0) begin
      abort_run("stim file ended with expected beats that were never run");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/tpl_dac.sv
// ********************
// tpl_dac
// JESD204 tx transport layer, Wishbone register map
// joined to the sample core
// ********************

`timescale 1ns/1ps
`default_nettype none

module tpl_dac
  import tpl_dac_pkg::*;
#(
  parameter logic [31:0] ID = 32'h0001_0000
) (
  input  wire                               link_clk,
  input  wire                               rst,

  // wishbone classic
  input  wire                               wb_cyc,
  input  wire                               wb_stb,
  input  wire                               wb_we,
  input  wire        [7:0]                  wb_adr,
  input  wire        [31:0]                 wb_dat_w,
  input  wire        [3:0]                  wb_sel,
  output logic       [31:0]                 wb_dat_r,
  output logic                              wb_ack,

  // jesd link
  output logic                              link_valid,
  input  wire                               link_ready,
  output link_beat_u                        link_data,

  // dma
  output logic       [num_channels-1:0]     enable,
  output logic       [num_channels-1:0]     dac_valid,
  input  wire chan_beat_t [num_channels-1:0] dac_ddata,
  input  wire                               dac_dunf
);

  logic                          run;
  logic                          dunf_event;
  chan_cfg_t [num_channels-1:0]  chan_cfg;

  tpl_dac_regmap #(
    .ID (ID)
  ) i_regmap (
    .link_clk   (link_clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .dunf_event (dunf_event),
    .run        (run),
    .chan_cfg   (chan_cfg),
    .enable     (enable)
  );

  tpl_dac_core i_core (
    .link_clk   (link_clk),
    .rst        (rst),
    .run        (run),
    .chan_cfg   (chan_cfg),
    .link_ready (link_ready),
    .dac_ddata  (dac_ddata),
    .dac_dunf   (dac_dunf),
    .link_valid (link_valid),
    .link_data  (link_data),
    .dac_valid  (dac_valid),
    .dunf_event (dunf_event)
  );

endmodule

`default_nettype wire

//--- hw/tpl_dac_core.sv
// ********************
// tpl_dac_core
// link pacing, dma requests, the channel sources and
// the framer, all on link_clk
// ********************

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_core
  import tpl_dac_pkg::*;
(
  input  wire                               link_clk,
  input  wire                               rst,
  input  wire                               run,
  input  wire chan_cfg_t  [num_channels-1:0] chan_cfg,
  input  wire                               link_ready,
  input  wire chan_beat_t [num_channels-1:0] dac_ddata,
  input  wire                               dac_dunf,
  output logic                              link_valid,
  output link_beat_u                        link_data,
  output logic            [num_channels-1:0] dac_valid,
  output logic                              dunf_event
);

  logic restart;
  logic advance;

  chan_beat_t [num_channels-1:0] beats;

  always_ff @(posedge link_clk) begin
    if (rst) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= run;
    end
  end

  // link_valid is run one cycle late, so this is the run edge
  assign restart = run & ~link_valid;

  // the restart cycle only clears the pipeline
  assign advance = run & (link_ready | ~link_valid) & ~restart;

  always_comb begin
    for (int c = 0; c < num_channels; c++) begin
      dac_valid[c] = advance & (chan_cfg[c].data_sel == src_dma);
    end
  end

  assign dunf_event = (|dac_valid) & dac_dunf;

  for (genvar c = 0; c < num_channels; c++) begin : g_chan
    tpl_dac_channel i_channel (
      .link_clk (link_clk),
      .rst      (rst),
      .advance  (advance),
      .restart  (restart),
      .cfg      (chan_cfg[c]),
      .dma_data (dac_ddata[c]),
      .beat     (beats[c])
    );
  end

  tpl_dac_framer i_framer (
    .link_clk   (link_clk),
    .rst        (rst),
    .advance    (advance),
    .restart    (restart),
    .link_valid (link_valid),
    .beats      (beats),
    .link_data  (link_data)
  );

endmodule

`default_nettype wire

//--- hw/tpl_dac_framer.sv
// ********************
// tpl_dac_framer
// maps the channel samples of a beat onto lane octets,
// most significant octet first, and holds the link word
// ********************

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_framer
  import tpl_dac_pkg::*;
(
  input  wire                               link_clk,
  input  wire                               rst,
  input  wire                               advance,
  input  wire                               restart,
  input  wire                               link_valid,
  input  wire chan_beat_t [num_channels-1:0] beats,
  output link_beat_u                        link_data
);

  localparam int octets_per_sample = bits_per_sample / 8;

  link_beat_u frame;

  // channel c on lane c, sample 0 first, high octet first
  always_comb begin
    int base;
    frame = '0;
    for (int c = 0; c < num_channels; c++) begin
      for (int s = 0; s < samples_per_beat; s++) begin
        base = c * octets_per_beat + s * octets_per_sample;
        for (int k = 0; k < octets_per_sample; k++) begin
          frame.octets[base + k] = beats[c][s][bits_per_sample - 1 - 8 * k -: 8];
        end
      end
    end
  end

  // ********************
  // link register
  // ********************

  always_ff @(posedge link_clk) begin
    if (rst) begin
      link_data <= '0;
    end else if (restart) begin
      link_data <= '0;
    end else if (advance) begin
      for (int i = 0; i < link_width / 8; i++) begin
        link_data.octets[i] <= frame.octets[i];
      end
    end
  end

  // no unknown bits on an offered beat
  link_data_known: assert property (@(posedge link_clk) disable iff (rst)
    link_valid |-> !$isunknown(link_data.lanes));

endmodule

`default_nettype wire

//--- hw/tpl_dac_channel.sv
// ********************
// tpl_dac_channel
// picks one channel's samples from DMA, a two word pattern,
// a linear ramp or zero and registers one beat per advance
// ********************

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_channel
  import tpl_dac_pkg::*;
(
  input  wire             link_clk,
  input  wire             rst,
  input  wire             advance,
  input  wire             restart,
  input  wire chan_cfg_t  cfg,
  input  wire chan_beat_t dma_data,
  output chan_beat_t      beat
);

  sample_t    acc;
  sample_t    ramp_end;
  chan_beat_t beat_next;

  // ********************
  // source select
  // ********************

  always_comb begin
    sample_t ramp_val;
    ramp_val  = acc;
    beat_next = '0;
    for (int s = 0; s < samples_per_beat; s++) begin
      case (cfg.data_sel)
        src_dma:     beat_next[s] = dma_data[s];
        src_pattern: beat_next[s] = s[0] ? cfg.pat_1 : cfg.pat_0;
        src_ramp:    beat_next[s] = ramp_val;
        default:     beat_next[s] = '0;
      endcase
      // 16 bit wrap
      ramp_val = ramp_val + cfg.ramp_incr;
    end
    ramp_end = ramp_val;
  end

  // ********************
  // beat register
  // ********************

  always_ff @(posedge link_clk) begin
    if (rst) begin
      acc  <= '0;
      beat <= '0;
    end else if (restart) begin
      acc  <= cfg.ramp_init;
      beat <= '0;
    end else if (advance) begin
      beat <= beat_next;
      // accumulator only moves while the ramp is selected
      if (cfg.data_sel == src_ramp) begin
        acc <= ramp_end;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/tpl_dac_regmap.sv
// ********************
// tpl_dac_regmap
// Wishbone classic slave for the ID, control, status and
// per-channel source configuration registers
// every access acks one cycle after cyc and stb
// ********************

`timescale 1ns/1ps
`default_nettype none

module tpl_dac_regmap
  import tpl_dac_pkg::*;
#(
  parameter logic [31:0] ID = 32'h0
) (
  input  wire                               link_clk,
  input  wire                               rst,

  input  wire                               wb_cyc,
  input  wire                               wb_stb,
  input  wire                               wb_we,
  input  wire        [7:0]                  wb_adr,
  input  wire        [31:0]                 wb_dat_w,
  input  wire        [3:0]                  wb_sel,
  output logic       [31:0]                 wb_dat_r,
  output logic                              wb_ack,

  input  wire                               dunf_event,

  output logic                              run,
  output chan_cfg_t  [num_channels-1:0]     chan_cfg,
  output logic       [num_channels-1:0]     enable
);

  // octets per frame, M*S*NP / (8*L)
  localparam logic [7:0] jesd_f = 8'(num_channels * bits_per_sample / (8 * num_lanes));

  logic        access;
  logic        wr;
  logic        underflow;
  logic [31:0] rd_data;
  logic [31:0] jesd_word;

  // data_sel, pattern and ramp words of each channel
  logic [num_channels-1:0][2:0][31:0] chan_words;
  logic [num_channels-1:0][2:0][31:0] chan_wr_words;

  function automatic logic [31:0] byte_merge(input logic [31:0] cur,
                                             input logic [31:0] din,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = din[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [7:0] chan_adr(input int ch, input int word);
    return 8'(reg_chan_base + ch * reg_chan_stride + word * 4);
  endfunction

  assign access    = wb_cyc & wb_stb & ~wb_ack;
  assign wr        = access & wb_we;
  assign jesd_word = {8'(bits_per_sample), jesd_f, 8'(num_lanes), 8'(num_channels)};

  always_comb begin
    for (int c = 0; c < num_channels; c++) begin
      chan_words[c][0] = {30'b0, chan_cfg[c].data_sel};
      chan_words[c][1] = {chan_cfg[c].pat_1, chan_cfg[c].pat_0};
      chan_words[c][2] = {chan_cfg[c].ramp_incr, chan_cfg[c].ramp_init};
      for (int w = 0; w < 3; w++) begin
        chan_wr_words[c][w] = byte_merge(chan_words[c][w], wb_dat_w, wb_sel);
      end
    end
  end

  // ********************
  // read mux
  // ********************

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      reg_id:     rd_data = ID;
      reg_ctrl:   rd_data = {31'b0, run};
      reg_status: rd_data = {31'b0, underflow};
      reg_jesd:   rd_data = jesd_word;
      default: begin
        for (int c = 0; c < num_channels; c++) begin
          for (int w = 0; w < 3; w++) begin
            if (wb_adr == chan_adr(c, w)) begin
              rd_data = chan_words[c][w];
            end
          end
        end
      end
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  always_ff @(posedge link_clk) begin
    if (access) begin
      wb_dat_r <= rd_data;
    end
  end

  // ********************
  // write side
  // ********************

  always_ff @(posedge link_clk) begin
    if (rst) begin
      run       <= 1'b0;
      underflow <= 1'b0;
      for (int c = 0; c < num_channels; c++) begin
        chan_cfg[c]          <= '0;
        chan_cfg[c].data_sel <= src_zero;
      end
    end else begin
      if (wr && wb_adr == reg_ctrl && wb_sel[0]) begin
        run <= wb_dat_w[0];
      end
      // write 1 clears, a new event wins
      if (dunf_event) begin
        underflow <= 1'b1;
      end else if (wr && wb_adr == reg_status && wb_sel[0] && wb_dat_w[0]) begin
        underflow <= 1'b0;
      end
      for (int c = 0; c < num_channels; c++) begin
        if (wr && wb_adr == chan_adr(c, 0)) begin
          chan_cfg[c].data_sel <= data_sel_e'(chan_wr_words[c][0][1:0]);
        end
        if (wr && wb_adr == chan_adr(c, 1)) begin
          chan_cfg[c].pat_0 <= chan_wr_words[c][1][15:0];
          chan_cfg[c].pat_1 <= chan_wr_words[c][1][31:16];
        end
        if (wr && wb_adr == chan_adr(c, 2)) begin
          chan_cfg[c].ramp_init <= chan_wr_words[c][2][15:0];
          chan_cfg[c].ramp_incr <= chan_wr_words[c][2][31:16];
        end
      end
    end
  end

  // dma request enables
  always_ff @(posedge link_clk) begin
    if (rst) begin
      enable <= '0;
    end else begin
      for (int c = 0; c < num_channels; c++) begin
        enable[c] <= (chan_cfg[c].data_sel == src_dma);
      end
    end
  end

  ack_needs_stb: assert property (@(posedge link_clk) disable iff (rst)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

  ack_single_cycle: assert property (@(posedge link_clk) disable iff (rst)
    wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- hw/tpl_dac_pkg.sv
// ********************
// tpl_dac_pkg
// converter geometry, register map offsets and the shared
// datapath types of the JESD204 transmit transport layer
// ********************

`default_nettype none

package tpl_dac_pkg;

  // geometry M=2 L=2 S=1 NP=16, four octets per beat
  localparam int num_channels     = 2;
  localparam int num_lanes        = 2;
  localparam int octets_per_beat  = 4;
  localparam int bits_per_sample  = 16;
  localparam int samples_per_beat = 2;
  localparam int link_width       = 64;

  // byte addresses
  localparam logic [7:0] reg_id          = 8'h00;
  localparam logic [7:0] reg_ctrl        = 8'h04;
  localparam logic [7:0] reg_status      = 8'h08;
  localparam logic [7:0] reg_jesd        = 8'h0C;
  localparam logic [7:0] reg_chan_base   = 8'h40;
  localparam logic [7:0] reg_chan_stride = 8'h10;

  typedef logic signed [bits_per_sample-1:0] sample_t;

  typedef enum logic [1:0] {
    src_dma     = 2'd0,
    src_pattern = 2'd1,
    src_ramp    = 2'd2,
    src_zero    = 2'd3
  } data_sel_e;

  typedef struct packed {
    data_sel_e data_sel;
    sample_t   pat_0;
    sample_t   pat_1;
    sample_t   ramp_init;
    sample_t   ramp_incr;
  } chan_cfg_t;

  // sample 0 is the earlier one
  typedef sample_t [samples_per_beat-1:0] chan_beat_t;

  // lane word c sits at bits [c*32 +: 32], octet 0 in its low byte
  typedef union packed {
    logic [num_lanes-1:0][octets_per_beat*8-1:0] lanes;
    logic [link_width/8-1:0][7:0]                octets;
  } link_beat_u;

endpackage

`default_nettype wire
